// ==== list.f ====
+incdir+include
rtl/procyon_types.sv
rtl/reservation_station.sv
rtl/ieu.sv
rtl/mdu.sv
rtl/completion_buffer.sv
rtl/procyon_exec.sv
test/procyon_exec_tb.sv

// ==== Makefile ====
BIN := obj_dir/Vprocyon_exec_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module procyon_exec_tb \
		-f list.f -o Vprocyon_exec_tb

run: build
	$(BIN) 2>&1 | tee sim.log
	@grep -qx "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall +incdir+include --top-module procyon_exec \
		rtl/procyon_types.sv rtl/reservation_station.sv rtl/ieu.sv \
		rtl/mdu.sv rtl/completion_buffer.sv rtl/procyon_exec.sv

clean:
	rm -rf obj_dir sim.log

// ==== test/procyon_exec_tb.sv ====
`timescale 1ns/1ps
`include "procyon_defines.svh"

module procyon_exec_tb;

    localparam N_ALU          = 12;
    localparam N_MUL          = 8;
    localparam N_CHAIN        = 12;
    localparam N_BURST        = 10;
    localparam N_RAND         = 2000;
    localparam TOTAL_OPS      = N_ALU + N_MUL + N_CHAIN + N_BURST + N_RAND;
    localparam TIMEOUT_CYCLES = 20 * TOTAL_OPS + 100;

    logic                            clk;
    logic                            i_rst;
    logic                            i_disp_en;
    procyon_types::procyon_opcode_t  i_disp_opcode;
    procyon_types::procyon_tag_t     i_disp_src_tag    [0:1];
    procyon_types::procyon_data_t    i_disp_src_data   [0:1];
    logic                            i_disp_src_is_tag [0:1];
    logic                            o_disp_stall;
    procyon_types::procyon_tag_t     o_disp_tag;
    logic                            o_retire_en;
    procyon_types::procyon_tag_t     o_retire_tag;
    procyon_types::procyon_data_t    o_retire_data;

    // Program-order model where producer -1 marks an immediate
    int                              op_prod   [0:TOTAL_OPS-1][0:1];
    procyon_types::procyon_data_t    op_imm    [0:TOTAL_OPS-1][0:1];
    procyon_types::procyon_data_t    op_result [0:TOTAL_OPS-1];
    int                              exp_q [$];
    int                              n_ops;
    int                              retired_count;
    int                              stall_cycles;
    int                              cycle_count;

    always #2 clk = ~clk;

    procyon_exec UUT (
        .clk(clk), .i_rst(i_rst),
        .i_disp_en(i_disp_en), .i_disp_opcode(i_disp_opcode),
        .i_disp_src_tag(i_disp_src_tag), .i_disp_src_data(i_disp_src_data),
        .i_disp_src_is_tag(i_disp_src_is_tag),
        .o_disp_stall(o_disp_stall), .o_disp_tag(o_disp_tag),
        .o_retire_en(o_retire_en), .o_retire_tag(o_retire_tag), .o_retire_data(o_retire_data)
    );

    function automatic procyon_types::procyon_data_t expected_result(
        input procyon_types::procyon_opcode_t op,
        input procyon_types::procyon_data_t   a,
        input procyon_types::procyon_data_t   b
    );
        logic [2*`DATA_WIDTH-1:0] prod;
        prod = {{`DATA_WIDTH{1'b0}}, a} * {{`DATA_WIDTH{1'b0}}, b};
        case (op)
            procyon_types::OPCODE_ADD:  return a + b;
            procyon_types::OPCODE_SUB:  return a - b;
            procyon_types::OPCODE_AND:  return a & b;
            procyon_types::OPCODE_OR:   return a | b;
            procyon_types::OPCODE_XOR:  return a ^ b;
            procyon_types::OPCODE_SLL:  return a << b[4:0];
            procyon_types::OPCODE_SRL:  return a >> b[4:0];
            procyon_types::OPCODE_MULH: return prod[2*`DATA_WIDTH-1:`DATA_WIDTH];
            default:                    return prod[`DATA_WIDTH-1:0];
        endcase
    endfunction

    // Indices 0 to 6 pick ALU opcodes and 7 to 8 the multiplies
    function automatic procyon_types::procyon_opcode_t opcode_from_index(input int k);
        case (k)
            0:       return procyon_types::OPCODE_ADD;
            1:       return procyon_types::OPCODE_SUB;
            2:       return procyon_types::OPCODE_AND;
            3:       return procyon_types::OPCODE_OR;
            4:       return procyon_types::OPCODE_XOR;
            5:       return procyon_types::OPCODE_SLL;
            6:       return procyon_types::OPCODE_SRL;
            7:       return procyon_types::OPCODE_MUL;
            default: return procyon_types::OPCODE_MULH;
        endcase
    endfunction

    // Tags are handed out in order from zero after reset
    function automatic procyon_types::procyon_tag_t tag_of(input int idx);
        return procyon_types::procyon_tag_t'(idx % `CB_DEPTH);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // A source goes out as a tag only while its producer is still in flight
    task automatic drive_sources(input int idx);
        int p;
        for (int s = 0; s < 2; s++) begin
            p = op_prod[idx][s];
            i_disp_src_tag[s] = '0;
            if (p < 0) begin
                i_disp_src_is_tag[s] = 1'b0;
                i_disp_src_data[s]   = op_imm[idx][s];
            end else if (p >= retired_count) begin
                i_disp_src_is_tag[s] = 1'b1;
                i_disp_src_tag[s]    = tag_of(p);
                i_disp_src_data[s]   = ~op_result[p];
            end else begin
                i_disp_src_is_tag[s] = 1'b0;
                i_disp_src_data[s]   = op_result[p];
            end
        end
    endtask

    // Entered and left 0.5 ns after a rising edge
    task automatic issue_op(input procyon_types::procyon_opcode_t op,
                            input int p0, input procyon_types::procyon_data_t d0,
                            input int p1, input procyon_types::procyon_data_t d1);
        int idx;
        procyon_types::procyon_data_t a;
        procyon_types::procyon_data_t b;
        idx = n_ops;
        op_prod[idx][0] = p0;
        op_prod[idx][1] = p1;
        op_imm[idx][0]  = d0;
        op_imm[idx][1]  = d1;
        a = (p0 >= 0) ? op_result[p0] : d0;
        b = (p1 >= 0) ? op_result[p1] : d1;
        op_result[idx] = expected_result(op, a, b);
        n_ops++;
        i_disp_en     = 1'b1;
        i_disp_opcode = op;
        drive_sources(idx);
        @(negedge clk);
        while (o_disp_stall) begin
            stall_cycles++;
            @(posedge clk);
            #0.5;
            drive_sources(idx);
            @(negedge clk);
        end
        check_value("o_disp_tag", 32'(o_disp_tag), 32'(tag_of(idx)));
        @(posedge clk);
        exp_q.push_back(idx);
        #0.5;
        i_disp_en = 1'b0;
    endtask

    // One retirement checked per low clock phase with o_retire_en
    always @(negedge clk) begin : compare_retire
        int idx;
        if (!i_rst && o_retire_en) begin
            if (exp_q.size() == 0) begin
                fail_run("Retirement seen with no operation outstanding");
            end else begin
                idx = exp_q.pop_front();
                check_value("o_retire_tag", 32'(o_retire_tag), 32'(tag_of(idx)));
                check_value("o_retire_data", o_retire_data, op_result[idx]);
                retired_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d operations retired",
                               cycle_count, retired_count, n_ops));
        end
    end

    initial begin
        int p [0:1];
        procyon_types::procyon_data_t d [0:1];
        int base;
        int range;
        int stall_mark;
        void'($urandom(32'h44b1_d1e0));
        clk           = 1'b0;
        i_rst         = 1'b1;
        i_disp_en     = 1'b0;
        i_disp_opcode = procyon_types::OPCODE_ADD;
        for (int s = 0; s < 2; s++) begin
            i_disp_src_tag[s]    = '0;
            i_disp_src_data[s]   = '0;
            i_disp_src_is_tag[s] = 1'b0;
        end
        n_ops         = 0;
        retired_count = 0;
        stall_cycles  = 0;
        cycle_count   = 0;
        repeat (10) @(posedge clk);
        #0.5;
        i_rst = 1'b0;

        @(negedge clk);
        check_value("o_disp_stall", 32'(o_disp_stall), 32'h0);
        check_value("o_retire_en", 32'(o_retire_en), 32'h0);
        check_value("o_disp_tag", 32'(o_disp_tag), 32'h0);
        @(posedge clk);
        #0.5;

        // Enough independent ALU operations to wrap the tags
        for (int k = 0; k < N_ALU; k++) begin
            issue_op(opcode_from_index(k % 7), -1, $urandom, -1, $urandom);
        end

        issue_op(procyon_types::OPCODE_MUL,  -1, 32'hffff_ffff, -1, 32'hffff_ffff);
        issue_op(procyon_types::OPCODE_MULH, -1, 32'hffff_ffff, -1, 32'hffff_ffff);
        issue_op(procyon_types::OPCODE_MUL,  -1, 32'h1234_5678, -1, 32'h9abc_def0);
        issue_op(procyon_types::OPCODE_MULH, -1, 32'h1234_5678, -1, 32'h9abc_def0);
        issue_op(procyon_types::OPCODE_MUL,  -1, 32'h8000_0001, -1, 32'h0000_0003);
        issue_op(procyon_types::OPCODE_MULH, -1, 32'h8000_0001, -1, 32'h0000_0003);
        d[0] = $urandom;
        d[1] = $urandom;
        issue_op(procyon_types::OPCODE_MUL,  -1, d[0], -1, d[1]);
        issue_op(procyon_types::OPCODE_MULH, -1, d[0], -1, d[1]);

        // ALU work waits on a multiply while a younger XOR finishes first
        for (int k = 0; k < N_CHAIN / 4; k++) begin
            base = n_ops;
            issue_op(procyon_types::OPCODE_MUL, -1, $urandom, -1, $urandom);
            issue_op(procyon_types::OPCODE_ADD, base, '0, -1, $urandom);
            issue_op(procyon_types::OPCODE_XOR, -1, $urandom, -1, $urandom);
            issue_op(procyon_types::OPCODE_MULH, base + 1, '0, base, '0);
        end

        // Multiplies stuck behind one producer fill the small station
        stall_mark = stall_cycles;
        base = n_ops;
        issue_op(procyon_types::OPCODE_MUL, -1, $urandom, -1, $urandom);
        for (int k = 1; k < N_BURST; k++) begin
            issue_op(opcode_from_index(7 + (k % 2)), base, '0, -1, $urandom);
        end
        if (stall_cycles == stall_mark) begin
            fail_run("Dispatch never stalled during the multiply burst");
        end

        for (int k = 0; k < N_RAND; k++) begin
            range = (n_ops < 6) ? n_ops : 6;
            for (int s = 0; s < 2; s++) begin
                d[s] = $urandom;
                p[s] = -1;
                if ((range > 0) && ($urandom % 2 == 1)) begin
                    p[s] = n_ops - 1 - int'($urandom % range);
                end
            end
            issue_op(opcode_from_index(int'($urandom % 9)), p[0], d[0], p[1], d[1]);
        end

        while (retired_count < n_ops) begin
            @(posedge clk);
        end
        // Idle cycles expose any extra retirement
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_value("o_disp_tag", 32'(o_disp_tag), 32'(tag_of(n_ops)));
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== rtl/procyon_exec.sv ====
`timescale 1ns/1ps
`include "procyon_defines.svh"

module procyon_exec (
    input  logic                            clk,
    input  logic                            i_rst,

    input  logic                            i_disp_en,
    input  procyon_types::procyon_opcode_t  i_disp_opcode,
    input  procyon_types::procyon_tag_t     i_disp_src_tag    [0:1],
    input  procyon_types::procyon_data_t    i_disp_src_data   [0:1],
    input  logic                            i_disp_src_is_tag [0:1],
    output logic                            o_disp_stall,
    output procyon_types::procyon_tag_t     o_disp_tag,

    output logic                            o_retire_en,
    output procyon_types::procyon_tag_t     o_retire_tag,
    output procyon_types::procyon_data_t    o_retire_data
);

    logic                            is_mdu;
    logic                            accept;
    logic                            cb_full;
    logic                            rs_full     [0:1];
    logic                            lookup_rdy  [0:1];
    procyon_types::procyon_data_t    lookup_data [0:1];
    logic                            rs_src_rdy  [0:1];
    procyon_types::procyon_data_t    rs_src_data [0:1];

    logic                            fu_valid  [0:`CDB_DEPTH-1];
    procyon_types::procyon_opcode_t  fu_opcode [0:`CDB_DEPTH-1];
    procyon_types::procyon_data_t    fu_src_a  [0:`CDB_DEPTH-1];
    procyon_types::procyon_data_t    fu_src_b  [0:`CDB_DEPTH-1];
    procyon_types::procyon_tag_t     fu_tag    [0:`CDB_DEPTH-1];

    logic                            cdb_en    [0:`CDB_DEPTH-1];
    procyon_types::procyon_tag_t     cdb_tag   [0:`CDB_DEPTH-1];
    procyon_types::procyon_data_t    cdb_data  [0:`CDB_DEPTH-1];

    assign is_mdu       = (i_disp_opcode == procyon_types::OPCODE_MUL) ||
                          (i_disp_opcode == procyon_types::OPCODE_MULH);
    assign o_disp_stall = cb_full | (is_mdu ? rs_full[1] : rs_full[0]);
    assign accept       = i_disp_en & ~o_disp_stall;

    // Immediate sources are always ready
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rs_src_rdy[s]  = i_disp_src_is_tag[s] ? lookup_rdy[s] : 1'b1;
            rs_src_data[s] = i_disp_src_is_tag[s] ? lookup_data[s] : i_disp_src_data[s];
        end
    end

    completion_buffer cb_inst (
        .clk(clk), .i_rst(i_rst),
        .i_alloc_en(accept), .o_alloc_tag(o_disp_tag), .o_full(cb_full),
        .i_lookup_tag(i_disp_src_tag), .o_lookup_rdy(lookup_rdy), .o_lookup_data(lookup_data),
        .i_cdb_en(cdb_en), .i_cdb_tag(cdb_tag), .i_cdb_data(cdb_data),
        .o_retire_en(o_retire_en), .o_retire_tag(o_retire_tag), .o_retire_data(o_retire_data)
    );

    reservation_station #(
        .RS_DEPTH(`RS_IEU_DEPTH)
    ) rs_ieu_inst (
        .clk(clk), .i_rst(i_rst),
        .i_rs_en(accept & ~is_mdu), .i_rs_opcode(i_disp_opcode),
        .i_rs_src_tag(i_disp_src_tag), .i_rs_src_data(rs_src_data), .i_rs_src_rdy(rs_src_rdy),
        .i_rs_dst_tag(o_disp_tag), .o_rs_full(rs_full[0]),
        .i_cdb_en(cdb_en), .i_cdb_tag(cdb_tag), .i_cdb_data(cdb_data),
        .o_fu_valid(fu_valid[0]), .o_fu_opcode(fu_opcode[0]),
        .o_fu_src_a(fu_src_a[0]), .o_fu_src_b(fu_src_b[0]), .o_fu_tag(fu_tag[0])
    );

    reservation_station #(
        .RS_DEPTH(`RS_MDU_DEPTH)
    ) rs_mdu_inst (
        .clk(clk), .i_rst(i_rst),
        .i_rs_en(accept & is_mdu), .i_rs_opcode(i_disp_opcode),
        .i_rs_src_tag(i_disp_src_tag), .i_rs_src_data(rs_src_data), .i_rs_src_rdy(rs_src_rdy),
        .i_rs_dst_tag(o_disp_tag), .o_rs_full(rs_full[1]),
        .i_cdb_en(cdb_en), .i_cdb_tag(cdb_tag), .i_cdb_data(cdb_data),
        .o_fu_valid(fu_valid[1]), .o_fu_opcode(fu_opcode[1]),
        .o_fu_src_a(fu_src_a[1]), .o_fu_src_b(fu_src_b[1]), .o_fu_tag(fu_tag[1])
    );

    ieu ieu_inst (
        .clk(clk), .i_rst(i_rst),
        .i_fu_valid(fu_valid[0]), .i_fu_opcode(fu_opcode[0]),
        .i_fu_src_a(fu_src_a[0]), .i_fu_src_b(fu_src_b[0]), .i_fu_tag(fu_tag[0]),
        .o_cdb_en(cdb_en[0]), .o_cdb_tag(cdb_tag[0]), .o_cdb_data(cdb_data[0])
    );

    mdu mdu_inst (
        .clk(clk), .i_rst(i_rst),
        .i_fu_valid(fu_valid[1]), .i_fu_opcode(fu_opcode[1]),
        .i_fu_src_a(fu_src_a[1]), .i_fu_src_b(fu_src_b[1]), .i_fu_tag(fu_tag[1]),
        .o_cdb_en(cdb_en[1]), .o_cdb_tag(cdb_tag[1]), .o_cdb_data(cdb_data[1])
    );

endmodule

// ==== rtl/completion_buffer.sv ====
`timescale 1ns/1ps
`include "procyon_defines.svh"

module completion_buffer (
    input  logic                          clk,
    input  logic                          i_rst,

    input  logic                          i_alloc_en,
    output procyon_types::procyon_tag_t   o_alloc_tag,
    output logic                          o_full,

    input  procyon_types::procyon_tag_t   i_lookup_tag  [0:1],
    output logic                          o_lookup_rdy  [0:1],
    output procyon_types::procyon_data_t  o_lookup_data [0:1],

    input  logic                          i_cdb_en   [0:`CDB_DEPTH-1],
    input  procyon_types::procyon_tag_t   i_cdb_tag  [0:`CDB_DEPTH-1],
    input  procyon_types::procyon_data_t  i_cdb_data [0:`CDB_DEPTH-1],

    output logic                          o_retire_en,
    output procyon_types::procyon_tag_t   o_retire_tag,
    output procyon_types::procyon_data_t  o_retire_data
);

    procyon_types::procyon_tag_t   head;
    procyon_types::procyon_tag_t   tail;
    logic [`TAG_WIDTH:0]           count;
    logic                          done   [0:`CB_DEPTH-1];
    procyon_types::procyon_data_t  result [0:`CB_DEPTH-1];

    assign o_alloc_tag   = tail;
    assign o_full        = (count == (`TAG_WIDTH+1)'(`CB_DEPTH));

    assign o_retire_en   = done[head];
    assign o_retire_tag  = head;
    assign o_retire_data = result[head];

    // Stored result first, then same-cycle bus bypass
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_lookup_rdy[s]  = done[i_lookup_tag[s]];
            o_lookup_data[s] = result[i_lookup_tag[s]];
            for (int c = 0; c < `CDB_DEPTH; c++) begin
                if (i_cdb_en[c] && (i_cdb_tag[c] == i_lookup_tag[s])) begin
                    o_lookup_rdy[s]  = 1'b1;
                    o_lookup_data[s] = i_cdb_data[c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `CB_DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            // Tag width matches the depth, so pointers wrap naturally
            if (i_alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (o_retire_en) begin
                head       <= head + 1'b1;
                done[head] <= 1'b0;
            end
            count <= count + (`TAG_WIDTH+1)'(i_alloc_en) - (`TAG_WIDTH+1)'(o_retire_en);
            for (int c = 0; c < `CDB_DEPTH; c++) begin
                if (i_cdb_en[c]) begin
                    done[i_cdb_tag[c]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `CDB_DEPTH; c++) begin
            if (i_cdb_en[c]) begin
                result[i_cdb_tag[c]] <= i_cdb_data[c];
            end
        end
    end

endmodule

// ==== rtl/mdu.sv ====
`timescale 1ns/1ps
`include "procyon_defines.svh"

module mdu (
    input  logic                            clk,
    input  logic                            i_rst,

    input  logic                            i_fu_valid,
    input  procyon_types::procyon_opcode_t  i_fu_opcode,
    input  procyon_types::procyon_data_t    i_fu_src_a,
    input  procyon_types::procyon_data_t    i_fu_src_b,
    input  procyon_types::procyon_tag_t     i_fu_tag,

    output logic                            o_cdb_en,
    output procyon_types::procyon_tag_t     o_cdb_tag,
    output procyon_types::procyon_data_t    o_cdb_data
);

    localparam LAST = `MDU_STAGES - 1;

    logic                            valid_q  [0:LAST];
    procyon_types::procyon_tag_t     tag_q    [0:LAST];
    procyon_types::procyon_opcode_t  opcode_q [0:LAST-1];
    procyon_types::procyon_data_t    src_a_q;
    procyon_types::procyon_data_t    src_b_q;
    logic [2*`DATA_WIDTH-1:0]        prod_q   [1:LAST-1];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k <= LAST; k++) begin
                valid_q[k] <= 1'b0;
            end
        end else begin
            valid_q[0] <= i_fu_valid;
            for (int k = 1; k <= LAST; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]    <= i_fu_tag;
        opcode_q[0] <= i_fu_opcode;
        for (int k = 1; k <= LAST; k++) begin
            tag_q[k] <= tag_q[k-1];
        end
        for (int k = 1; k < LAST; k++) begin
            opcode_q[k] <= opcode_q[k-1];
        end
        src_a_q <= i_fu_src_a;
        src_b_q <= i_fu_src_b;
        // Unsigned full-width product
        prod_q[1] <= {{`DATA_WIDTH{1'b0}}, src_a_q} * {{`DATA_WIDTH{1'b0}}, src_b_q};
        for (int k = 2; k < LAST; k++) begin
            prod_q[k] <= prod_q[k-1];
        end
        o_cdb_data <= (opcode_q[LAST-1] == procyon_types::OPCODE_MULH) ?
                      prod_q[LAST-1][2*`DATA_WIDTH-1:`DATA_WIDTH] :
                      prod_q[LAST-1][`DATA_WIDTH-1:0];
    end

    assign o_cdb_en  = valid_q[LAST];
    assign o_cdb_tag = tag_q[LAST];

endmodule

// ==== rtl/ieu.sv ====
`timescale 1ns/1ps

module ieu (
    input  logic                            clk,
    input  logic                            i_rst,

    input  logic                            i_fu_valid,
    input  procyon_types::procyon_opcode_t  i_fu_opcode,
    input  procyon_types::procyon_data_t    i_fu_src_a,
    input  procyon_types::procyon_data_t    i_fu_src_b,
    input  procyon_types::procyon_tag_t     i_fu_tag,

    output logic                            o_cdb_en,
    output procyon_types::procyon_tag_t     o_cdb_tag,
    output procyon_types::procyon_data_t    o_cdb_data
);

    procyon_types::procyon_data_t  result;
    logic [4:0]                    shamt;

    assign shamt = i_fu_src_b[4:0];

    always_comb begin
        case (i_fu_opcode)
            procyon_types::OPCODE_ADD: result = i_fu_src_a + i_fu_src_b;
            procyon_types::OPCODE_SUB: result = i_fu_src_a - i_fu_src_b;
            procyon_types::OPCODE_AND: result = i_fu_src_a & i_fu_src_b;
            procyon_types::OPCODE_OR:  result = i_fu_src_a | i_fu_src_b;
            procyon_types::OPCODE_XOR: result = i_fu_src_a ^ i_fu_src_b;
            procyon_types::OPCODE_SLL: result = i_fu_src_a << shamt;
            procyon_types::OPCODE_SRL: result = i_fu_src_a >> shamt;
            default:                   result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_fu_valid;
        end
    end

    // Lane 0 payload
    always_ff @(posedge clk) begin
        o_cdb_tag  <= i_fu_tag;
        o_cdb_data <= result;
    end

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/1ps
`include "procyon_defines.svh"

module reservation_station #(
    parameter RS_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            i_rst,

    input  logic                            i_rs_en,
    input  procyon_types::procyon_opcode_t  i_rs_opcode,
    input  procyon_types::procyon_tag_t     i_rs_src_tag  [0:1],
    input  procyon_types::procyon_data_t    i_rs_src_data [0:1],
    input  logic                            i_rs_src_rdy  [0:1],
    input  procyon_types::procyon_tag_t     i_rs_dst_tag,
    output logic                            o_rs_full,

    input  logic                            i_cdb_en   [0:`CDB_DEPTH-1],
    input  procyon_types::procyon_tag_t     i_cdb_tag  [0:`CDB_DEPTH-1],
    input  procyon_types::procyon_data_t    i_cdb_data [0:`CDB_DEPTH-1],

    output logic                            o_fu_valid,
    output procyon_types::procyon_opcode_t  o_fu_opcode,
    output procyon_types::procyon_data_t    o_fu_src_a,
    output procyon_types::procyon_data_t    o_fu_src_b,
    output procyon_types::procyon_tag_t     o_fu_tag
);

    localparam IDX_WIDTH = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    procyon_types::rs_slot_state_t   slot_state    [0:RS_DEPTH-1];
    procyon_types::procyon_opcode_t  slot_opcode   [0:RS_DEPTH-1];
    procyon_types::procyon_tag_t     slot_dst_tag  [0:RS_DEPTH-1];
    procyon_types::procyon_tag_t     slot_src_tag  [0:RS_DEPTH-1][0:1];
    procyon_types::procyon_data_t    slot_src_data [0:RS_DEPTH-1][0:1];
    logic                            slot_src_rdy  [0:RS_DEPTH-1][0:1];
    // Number of younger entries still held
    logic [IDX_WIDTH-1:0]            slot_age      [0:RS_DEPTH-1];

    procyon_types::procyon_data_t    snoop_data    [0:RS_DEPTH-1][0:1];
    logic                            snoop_rdy     [0:RS_DEPTH-1][0:1];
    procyon_types::procyon_data_t    entry_data    [0:1];
    logic                            entry_rdy     [0:1];

    logic                            alloc_found;
    logic                            alloc_en;
    logic [IDX_WIDTH-1:0]            alloc_idx;
    logic                            issue_found;
    logic [IDX_WIDTH-1:0]            issue_idx;
    logic [IDX_WIDTH-1:0]            issue_age;

    // Operand capture from the bus, for held slots and the incoming entry
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                snoop_rdy[i][s]  = slot_src_rdy[i][s];
                snoop_data[i][s] = slot_src_data[i][s];
                for (int c = 0; c < `CDB_DEPTH; c++) begin
                    if (!slot_src_rdy[i][s] && i_cdb_en[c] &&
                        (i_cdb_tag[c] == slot_src_tag[i][s])) begin
                        snoop_rdy[i][s]  = 1'b1;
                        snoop_data[i][s] = i_cdb_data[c];
                    end
                end
            end
        end
        for (int s = 0; s < 2; s++) begin
            entry_rdy[s]  = i_rs_src_rdy[s];
            entry_data[s] = i_rs_src_data[s];
            for (int c = 0; c < `CDB_DEPTH; c++) begin
                if (!i_rs_src_rdy[s] && i_cdb_en[c] && (i_cdb_tag[c] == i_rs_src_tag[s])) begin
                    entry_rdy[s]  = 1'b1;
                    entry_data[s] = i_cdb_data[c];
                end
            end
        end
    end

    // Lowest free slot, and oldest ready slot
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        issue_found = 1'b0;
        issue_idx   = '0;
        issue_age   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (slot_state[i] == procyon_types::RS_IDLE) begin
                alloc_found = 1'b1;
                alloc_idx   = IDX_WIDTH'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if ((slot_state[i] == procyon_types::RS_READY) &&
                (!issue_found || (slot_age[i] > issue_age))) begin
                issue_found = 1'b1;
                issue_idx   = IDX_WIDTH'(i);
                issue_age   = slot_age[i];
            end
        end
    end

    assign o_rs_full   = ~alloc_found;
    assign alloc_en    = i_rs_en & alloc_found;

    assign o_fu_valid  = issue_found;
    assign o_fu_opcode = slot_opcode[issue_idx];
    assign o_fu_src_a  = slot_src_data[issue_idx][0];
    assign o_fu_src_b  = slot_src_data[issue_idx][1];
    assign o_fu_tag    = slot_dst_tag[issue_idx];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                slot_state[i] <= procyon_types::RS_IDLE;
                slot_age[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (issue_found && (issue_idx == IDX_WIDTH'(i))) begin
                    slot_state[i] <= procyon_types::RS_IDLE;
                end else if (slot_state[i] != procyon_types::RS_IDLE) begin
                    slot_state[i] <= (snoop_rdy[i][0] && snoop_rdy[i][1]) ?
                                     procyon_types::RS_READY : procyon_types::RS_WAIT;
                    // Older than the issuing entry loses one younger neighbour
                    slot_age[i]   <= slot_age[i] + IDX_WIDTH'(alloc_en) -
                                     IDX_WIDTH'(issue_found && (slot_age[i] > issue_age));
                end
            end
            if (alloc_en) begin
                slot_state[alloc_idx] <= (entry_rdy[0] && entry_rdy[1]) ?
                                         procyon_types::RS_READY : procyon_types::RS_WAIT;
                slot_age[alloc_idx]   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot_src_rdy[i]  <= snoop_rdy[i];
            slot_src_data[i] <= snoop_data[i];
        end
        if (alloc_en) begin
            slot_opcode[alloc_idx]   <= i_rs_opcode;
            slot_dst_tag[alloc_idx]  <= i_rs_dst_tag;
            slot_src_tag[alloc_idx]  <= i_rs_src_tag;
            slot_src_rdy[alloc_idx]  <= entry_rdy;
            slot_src_data[alloc_idx] <= entry_data;
        end
    end

endmodule

// ==== rtl/procyon_types.sv ====
`include "procyon_defines.svh"

package procyon_types;

    typedef logic [`DATA_WIDTH-1:0] procyon_data_t;
    typedef logic [`TAG_WIDTH-1:0]  procyon_tag_t;

    typedef enum logic [3:0] {
        OPCODE_ADD  = 4'h0,
        OPCODE_SUB  = 4'h1,
        OPCODE_AND  = 4'h2,
        OPCODE_OR   = 4'h3,
        OPCODE_XOR  = 4'h4,
        OPCODE_SLL  = 4'h5,
        OPCODE_SRL  = 4'h6,
        // Multiply unit opcodes
        OPCODE_MUL  = 4'h8,
        OPCODE_MULH = 4'h9
    } procyon_opcode_t;

    typedef enum logic [1:0] {
        RS_IDLE  = 2'b00,
        RS_WAIT  = 2'b01,
        RS_READY = 2'b10
    } rs_slot_state_t;

endpackage

// ==== include/procyon_defines.svh ====
`ifndef PROCYON_DEFINES_SVH
`define PROCYON_DEFINES_SVH

// Datapath
`define DATA_WIDTH      32
`define TAG_WIDTH       3

// Queue depths
`define CB_DEPTH        8
`define RS_IEU_DEPTH    4
`define RS_MDU_DEPTH    2

// One bus lane per functional unit
`define CDB_DEPTH       2

// Multiply latency, at least 3
`define MDU_STAGES      3

`endif
